// ==== logic/spi_pkg.sv ====
package spi_pkg;

  // Register bus address width, covers offsets 00h to 1Ch
  localparam int REG_ADDR_W = 5;

  // Word offsets inside the register window
  // Data offsets write TX and read RX
  localparam logic [REG_ADDR_W-1:0] RX0_TX0_OFS = 5'h00;
  localparam logic [REG_ADDR_W-1:0] RX1_TX1_OFS = 5'h04;
  localparam logic [REG_ADDR_W-1:0] CTRL_OFS    = 5'h10;
  localparam logic [REG_ADDR_W-1:0] DIVIDER_OFS = 5'h14;
  localparam logic [REG_ADDR_W-1:0] SS_OFS      = 5'h18;

  // Longest transfer in bits
  localparam int SPI_MAX_BITS = 64;

  // Serial flash read opcode, sent ahead of a 24-bit address
  localparam logic [7:0] XIP_READ_CMD = 8'h03;
  // SCK half period of two clocks during XIP
  localparam logic [31:0] XIP_DIVIDER = 32'd1;

  // CTRL register layout
  typedef struct packed {
    logic [18:0] rsvd_hi;
    logic        ie;
    logic [2:0]  rsvd_mid;
    logic        go_bsy;
    logic        rsvd_lo;
    // Zero encodes a full 64-bit transfer
    logic [6:0]  char_len;
  } spi_ctrl_t;

  // Bus word seen raw for data registers, as fields for CTRL
  typedef union packed {
    logic [31:0] raw;
    spi_ctrl_t   f;
  } spi_ctrl_u;

endpackage

// ==== logic/spi_reg_if.sv ====
`timescale 1ns/100ps

interface spi_reg_if;

  // Word offset into the register file
  logic [spi_pkg::REG_ADDR_W-1:0] adr;
  logic [31:0]                    wdata;
  // Valid in the ack cycle
  logic [31:0]                    rdata;
  // Byte lanes for writes
  logic [3:0]                     sel;
  logic                           we;
  // Held with stable request until ack or err
  logic                           stb;
  logic                           ack;
  logic                           err;

  modport host (output adr, wdata, sel, we, stb, input rdata, ack, err);
  modport device (input adr, wdata, sel, we, stb, output rdata, ack, err);

endinterface

// ==== logic/spi_shift_if.sv ====
`timescale 1ns/100ps

interface spi_shift_if;

  // Start pulse, engine latches the fields below with it
  logic                             go;
  logic [6:0]                       char_len;
  logic [31:0]                      divider;
  logic [spi_pkg::SPI_MAX_BITS-1:0] tx_data;
  // Received bits, valid from done onward
  logic [spi_pkg::SPI_MAX_BITS-1:0] rx_data;
  // Single-cycle end of transfer
  logic                             done;

  modport ctrl (output go, char_len, divider, tx_data, input rx_data, done);
  modport engine (input go, char_len, divider, tx_data, output rx_data, done);

endinterface

// ==== logic/apb_xip_front.sv ====
`timescale 1ns/100ps

module apb_xip_front #(
  parameter logic [31:0] FLASH_BASE  = 32'h3000_0000,
  parameter logic [31:0] FLASH_LIMIT = 32'h3FFF_FFFF,
  parameter logic [31:0] REGS_BASE   = 32'h1000_1000,
  parameter logic [31:0] REGS_LIMIT  = 32'h1000_1FFF
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  spi_reg_if.host     bus
);

  // XIP sequence states, one bus step each from CMD to READ
  localparam logic [3:0] ST_IDLE  = 4'd0;
  localparam logic [3:0] ST_CMD   = 4'd1;
  localparam logic [3:0] ST_DIV   = 4'd2;
  localparam logic [3:0] ST_SS    = 4'd3;
  localparam logic [3:0] ST_GO    = 4'd4;
  localparam logic [3:0] ST_POLL  = 4'd5;
  localparam logic [3:0] ST_DESEL = 4'd6;
  localparam logic [3:0] ST_READ  = 4'd7;
  localparam logic [3:0] ST_DONE  = 4'd8;

  logic [3:0]                     state;
  logic [31:0]                    xip_data;
  logic                           in_flash;
  logic                           in_regs;
  logic                           access;
  logic                           bad_access;
  logic                           xip_stb;
  logic                           xip_we;
  logic [spi_pkg::REG_ADDR_W-1:0] xip_adr;
  logic [31:0]                    xip_wdata;
  spi_pkg::spi_ctrl_u             start_word;
  spi_pkg::spi_ctrl_u             poll_word;

  // Window decode
  assign in_flash = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_LIMIT);
  assign in_regs = (paddr_i >= REGS_BASE) && (paddr_i <= REGS_LIMIT);
  // APB access phase
  assign access = psel_i && penable_i;
  // Flash writes and misses answer at once with an error
  assign bad_access = access && (in_flash ? pwrite_i : !in_regs);

  // Start word: 64 bits, no interrupt
  always_comb begin
    start_word.raw = '0;
    start_word.f.char_len = '0;
    start_word.f.go_bsy = 1'b1;
  end

  // CTRL as returned by a poll
  assign poll_word.raw = bus.rdata;

  // Request for the current step
  always_comb begin
    xip_stb = 1'b1;
    xip_we = 1'b1;
    xip_adr = spi_pkg::RX0_TX0_OFS;
    xip_wdata = '0;
    case (state)
      ST_CMD: begin
        // Opcode and address land in the upper transfer word
        xip_adr = spi_pkg::RX1_TX1_OFS;
        xip_wdata = {spi_pkg::XIP_READ_CMD, paddr_i[23:0]};
      end
      ST_DIV: begin
        xip_adr = spi_pkg::DIVIDER_OFS;
        xip_wdata = spi_pkg::XIP_DIVIDER;
      end
      ST_SS: begin
        // Flash sits on slave 0
        xip_adr = spi_pkg::SS_OFS;
        xip_wdata = 32'd1;
      end
      ST_GO: begin
        xip_adr = spi_pkg::CTRL_OFS;
        xip_wdata = start_word.raw;
      end
      ST_POLL: begin
        xip_adr = spi_pkg::CTRL_OFS;
        xip_we = 1'b0;
      end
      ST_DESEL: begin
        xip_adr = spi_pkg::SS_OFS;
      end
      ST_READ: begin
        // Last 32 received bits are the flash data
        xip_we = 1'b0;
      end
      default: begin
        xip_stb = 1'b0;
        xip_we = 1'b0;
      end
    endcase
  end

  // Bus mux, sequencer owns the bus outside idle
  always_comb begin
    if (state == ST_IDLE) begin
      bus.adr = paddr_i[spi_pkg::REG_ADDR_W-1:0];
      bus.wdata = pwdata_i;
      bus.sel = pstrb_i;
      bus.we = pwrite_i;
      bus.stb = access && in_regs;
    end else begin
      bus.adr = xip_adr;
      bus.wdata = xip_wdata;
      bus.sel = 4'hF;
      bus.we = xip_we;
      bus.stb = xip_stb;
    end
  end

  // APB response
  always_comb begin
    if (state == ST_IDLE) begin
      pready_o = bad_access || bus.ack || bus.err;
      pslverr_o = bad_access || bus.err;
      prdata_o = bus.rdata;
    end else begin
      // Held while the master keeps penable
      pready_o = (state == ST_DONE) && access;
      pslverr_o = 1'b0;
      prdata_o = xip_data;
    end
  end

  // Sequencer, each step advances on ack
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (access && in_flash && !pwrite_i) state <= ST_CMD;
        ST_CMD: if (bus.ack) state <= ST_DIV;
        ST_DIV: if (bus.ack) state <= ST_SS;
        ST_SS: if (bus.ack) state <= ST_GO;
        ST_GO: if (bus.ack) state <= ST_POLL;
        // Poll again until busy clears
        ST_POLL: if (bus.ack && !poll_word.f.go_bsy) state <= ST_DESEL;
        ST_DESEL: if (bus.ack) state <= ST_READ;
        ST_READ: if (bus.ack) state <= ST_DONE;
        ST_DONE: if (!penable_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // RX0 capture for PRDATA
  always_ff @(posedge clock) begin
    if (state == ST_READ && bus.ack) begin
      xip_data <= bus.rdata;
    end
  end

endmodule

// ==== logic/spi_master_regs.sv ====
`timescale 1ns/100ps

module spi_master_regs #(
  parameter int SS_NUM = 8
) (
  input  logic              clock,
  input  logic              reset,
  spi_reg_if.device         bus,
  spi_shift_if.ctrl         shift,
  output logic [SS_NUM-1:0] spi_ss_o,
  output logic              spi_irq_o
);

  localparam int MAX = spi_pkg::SPI_MAX_BITS;

  logic [31:0]        tx0;
  logic [31:0]        tx1;
  logic [31:0]        rx0;
  logic [31:0]        rx1;
  logic [31:0]        divider;
  logic [SS_NUM-1:0]  ss;
  logic [6:0]         char_len;
  logic               go_bsy;
  logic               ie;
  logic               access;
  logic               hit;
  logic               wr;
  logic [31:0]        lane_mask;
  logic [31:0]        rd_word;
  spi_pkg::spi_ctrl_u wr_ctrl;
  spi_pkg::spi_ctrl_u rd_ctrl;

  // New request, strobe not yet answered
  assign access = bus.stb && !bus.ack && !bus.err;
  assign wr = access && bus.we && hit;
  // Byte lanes expanded to bits
  assign lane_mask = {{8{bus.sel[3]}}, {8{bus.sel[2]}}, {8{bus.sel[1]}}, {8{bus.sel[0]}}};
  assign wr_ctrl.raw = bus.wdata;

  // CTRL as read back
  always_comb begin
    rd_ctrl.raw = '0;
    rd_ctrl.f.char_len = char_len;
    rd_ctrl.f.go_bsy = go_bsy;
    rd_ctrl.f.ie = ie;
  end

  // Offset decode and read mux
  always_comb begin
    hit = 1'b1;
    rd_word = '0;
    case (bus.adr)
      spi_pkg::RX0_TX0_OFS: rd_word = rx0;
      spi_pkg::RX1_TX1_OFS: rd_word = rx1;
      spi_pkg::CTRL_OFS:    rd_word = rd_ctrl.raw;
      spi_pkg::DIVIDER_OFS: rd_word = divider;
      spi_pkg::SS_OFS:      rd_word = 32'(ss);
      default:              hit = 1'b0;
    endcase
  end

  // One-cycle answer
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= access && hit;
      bus.err <= access && !hit;
    end
  end

  // Read data lines up with ack
  always_ff @(posedge clock) begin
    if (access) begin
      bus.rdata <= rd_word;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx0 <= '0;
      tx1 <= '0;
      rx0 <= '0;
      rx1 <= '0;
      divider <= '0;
      ss <= '0;
      char_len <= '0;
      go_bsy <= 1'b0;
      ie <= 1'b0;
      shift.go <= 1'b0;
      spi_irq_o <= 1'b0;
    end else begin
      shift.go <= 1'b0;
      if (wr) begin
        case (bus.adr)
          spi_pkg::RX0_TX0_OFS: tx0 <= (tx0 & ~lane_mask) | (bus.wdata & lane_mask);
          spi_pkg::RX1_TX1_OFS: tx1 <= (tx1 & ~lane_mask) | (bus.wdata & lane_mask);
          spi_pkg::DIVIDER_OFS: divider <= (divider & ~lane_mask) | (bus.wdata & lane_mask);
          spi_pkg::SS_OFS: begin
            ss <= (ss & ~lane_mask[SS_NUM-1:0]) | (bus.wdata[SS_NUM-1:0] & lane_mask[SS_NUM-1:0]);
          end
          spi_pkg::CTRL_OFS: begin
            // Any CTRL write acknowledges the interrupt
            spi_irq_o <= 1'b0;
            if (bus.sel[1]) ie <= wr_ctrl.f.ie;
            // Length and start only while idle
            if (!go_bsy) begin
              if (bus.sel[0]) char_len <= wr_ctrl.f.char_len;
              if (bus.sel[1] && wr_ctrl.f.go_bsy) begin
                go_bsy <= 1'b1;
                shift.go <= 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
      // Transfer end, capture RX and raise irq
      if (shift.done) begin
        go_bsy <= 1'b0;
        rx0 <= shift.rx_data[31:0];
        rx1 <= shift.rx_data[MAX-1:32];
        if (ie) spi_irq_o <= 1'b1;
      end
    end
  end

  assign shift.char_len = char_len;
  assign shift.divider = divider;
  // TX1 goes out first on long transfers
  assign shift.tx_data = {tx1, tx0};
  // Select pads are active low
  assign spi_ss_o = ~ss;

endmodule

// ==== logic/spi_shifter.sv ====
`timescale 1ns/100ps

module spi_shifter (
  input  logic        clock,
  input  logic        reset,
  input  logic        spi_miso_i,
  spi_shift_if.engine shift,
  output logic        spi_sck_o,
  output logic        spi_mosi_o
);

  localparam int MAX = spi_pkg::SPI_MAX_BITS;

  logic [MAX-1:0] sreg;
  logic [31:0]    div_q;
  logic [31:0]    cnt;
  // SCK edges still to come
  logic [7:0]     edges_left;
  logic [7:0]     bit_num;
  logic           busy;
  logic           tick;

  // Transfer length, zero means full width
  assign bit_num = (shift.char_len == '0) ? 8'(MAX) : {1'b0, shift.char_len};
  // Half period elapsed
  assign tick = busy && (cnt == '0);
  // MSB of the aligned word is always on the pin
  assign spi_mosi_o = sreg[MAX-1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      spi_sck_o <= 1'b0;
      cnt <= '0;
      div_q <= '0;
      edges_left <= '0;
      sreg <= '0;
      shift.done <= 1'b0;
    end else begin
      shift.done <= 1'b0;
      if (shift.go && !busy) begin
        busy <= 1'b1;
        div_q <= shift.divider;
        cnt <= shift.divider;
        edges_left <= bit_num << 1;
        // First bit moves to the top
        sreg <= shift.tx_data << (8'(MAX) - bit_num);
      end else if (busy) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          cnt <= div_q;
          spi_sck_o <= !spi_sck_o;
          edges_left <= edges_left - 1'b1;
          // Falling edge, next bit onto MOSI
          if (spi_sck_o) begin
            sreg <= sreg << 1;
            // Last falling edge leaves SCK low
            if (edges_left == 8'd1) begin
              busy <= 1'b0;
              shift.done <= 1'b1;
            end
          end
        end
      end
    end
  end

  // MISO into the low end on the rising edge
  always_ff @(posedge clock) begin
    if (tick && !spi_sck_o) begin
      shift.rx_data <= {shift.rx_data[MAX-2:0], spi_miso_i};
    end
  end

endmodule

// ==== logic/spi_apb_bridge.sv ====
`timescale 1ns/100ps

module spi_apb_bridge #(
  parameter logic [31:0] FLASH_BASE  = 32'h3000_0000,
  parameter logic [31:0] FLASH_LIMIT = 32'h3FFF_FFFF,
  parameter logic [31:0] REGS_BASE   = 32'h1000_1000,
  parameter logic [31:0] REGS_LIMIT  = 32'h1000_1FFF,
  parameter int          SS_NUM      = 8
) (
  input  logic              clock,
  input  logic              reset,
  // APB slave
  input  logic [31:0]       paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  input  logic [3:0]        pstrb_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  // SPI pads
  output logic              spi_sck_o,
  output logic [SS_NUM-1:0] spi_ss_o,
  output logic              spi_mosi_o,
  input  logic              spi_miso_i,
  output logic              spi_irq_o
);

  // Front end to register file
  spi_reg_if reg_bus ();
  // Register file to shift engine
  spi_shift_if shift_bus ();

  apb_xip_front #(
    .FLASH_BASE  (FLASH_BASE),
    .FLASH_LIMIT (FLASH_LIMIT),
    .REGS_BASE   (REGS_BASE),
    .REGS_LIMIT  (REGS_LIMIT)
  ) u_front (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .bus       (reg_bus)
  );

  spi_master_regs #(
    .SS_NUM (SS_NUM)
  ) u_regs (
    .clock     (clock),
    .reset     (reset),
    .bus       (reg_bus),
    .shift     (shift_bus),
    .spi_ss_o  (spi_ss_o),
    .spi_irq_o (spi_irq_o)
  );

  spi_shifter u_shifter (
    .clock      (clock),
    .reset      (reset),
    .spi_miso_i (spi_miso_i),
    .shift      (shift_bus),
    .spi_sck_o  (spi_sck_o),
    .spi_mosi_o (spi_mosi_o)
  );

endmodule

// ==== verif/spi_flash_model.sv ====
`timescale 1ns/100ps

module spi_flash_model (
  input  logic        sck_i,
  input  logic        ss_n_i,
  input  logic        mosi_i,
  output logic        miso_o,
  output logic [31:0] last_cmd_o
);

  logic [31:0] cmd_sr;
  // Four bytes returned after the command
  logic [31:0] data_word;
  // Opcode matched the read command
  logic        read_cmd = 1'b0;
  logic        miso_q = 1'b0;
  // Rising SCK edges since select
  int unsigned bit_cnt = 0;

  // Content rule, low address byte XOR A5h
  function automatic logic [7:0] mem_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'hA5;
  endfunction

  function automatic logic [31:0] read_word(input logic [23:0] addr);
    return {mem_byte(addr), mem_byte(addr + 24'd1), mem_byte(addr + 24'd2),
            mem_byte(addr + 24'd3)};
  endfunction

  // Mode 0, MOSI taken on rising SCK
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt <= 0;
      read_cmd <= 1'b0;
    end else begin
      cmd_sr <= {cmd_sr[30:0], mosi_i};
      bit_cnt <= bit_cnt + 1;
      // Opcode and address complete
      if (bit_cnt == 31) begin
        last_cmd_o <= {cmd_sr[30:0], mosi_i};
        data_word <= read_word({cmd_sr[22:0], mosi_i});
        read_cmd <= (cmd_sr[30:23] == spi_pkg::XIP_READ_CMD);
      end
    end
  end

  // Data goes out on falling SCK, MSB first
  always @(negedge sck_i) begin
    if (!ss_n_i && read_cmd && bit_cnt >= 32 && bit_cnt < 64) begin
      miso_q <= data_word[63 - bit_cnt];
    end else begin
      miso_q <= 1'b0;
    end
  end

  assign miso_o = miso_q;

endmodule

// ==== verif/spi_apb_assertions.sv ====
`timescale 1ns/100ps

module spi_apb_assertions #(
  parameter int SS_NUM = 8
) (
  input logic              clock,
  input logic              reset,
  input logic              psel_i,
  input logic              penable_i,
  input logic              pready_i,
  input logic              pslverr_i,
  input logic              spi_sck_i,
  input logic [SS_NUM-1:0] spi_ss_i
);

  // Failures seen so far, read by the testbench summary
  int unsigned fail_count = 0;

  // Error response only in a completing cycle
  slverr_with_ready: assert property (
    @(posedge clock) disable iff (reset) pslverr_i |-> pready_i
  ) else begin
    fail_count++;
    $error("pslverr high without pready");
  end

  // Ready only inside an access phase
  ready_in_access: assert property (
    @(posedge clock) disable iff (reset) pready_i |-> (psel_i && penable_i)
  ) else begin
    fail_count++;
    $error("pready high outside an APB access phase");
  end

  // No clock on the bus with every slave deselected
  sck_idle_unselected: assert property (
    @(posedge clock) disable iff (reset) (&spi_ss_i) |-> !spi_sck_i
  ) else begin
    fail_count++;
    $error("SCK toggled while no slave was selected");
  end

endmodule

// ==== verif/tb_spi_apb_bridge.sv ====
`timescale 1ns/100ps

module tb_spi_apb_bridge;

  localparam int          SS_NUM     = 8;
  localparam logic [31:0] REGS_BASE  = 32'h1000_1000;
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam int          XIP_READS  = 8;
  localparam int          MANUAL_DIV = 2;
  // Transfer of n bits takes 2n(divider+1) cycles
  localparam int MANUAL_CYCLES = 2 * 64 * (MANUAL_DIV + 1);
  localparam int XIP_CYCLES = 2 * 64 * (int'(spi_pkg::XIP_DIVIDER) + 1);
  localparam int TIMEOUT_CYCLES = 2 * (MANUAL_CYCLES + XIP_READS * XIP_CYCLES);

  logic              clock = 1'b0;
  logic              reset;
  logic [31:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [3:0]        pstrb;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              spi_sck;
  logic [SS_NUM-1:0] spi_ss;
  logic              spi_mosi;
  logic              spi_miso;
  logic              spi_irq;
  logic [31:0]       flash_cmd;
  logic [31:0]       lcg_state = 32'h9806;
  int                error_count = 0;
  int                check_count = 0;
  int                cycle_count = 0;

  spi_apb_bridge #(
    .SS_NUM (SS_NUM)
  ) dut (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash hangs on slave 0
  spi_flash_model flash (
    .sck_i      (spi_sck),
    .ss_n_i     (spi_ss[0]),
    .mosi_i     (spi_mosi),
    .miso_o     (spi_miso),
    .last_cmd_o (flash_cmd)
  );

  bind spi_apb_bridge spi_apb_assertions #(.SS_NUM(SS_NUM)) u_assert (
    .clock     (clock),
    .reset     (reset),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .spi_sck_i (spi_sck_o),
    .spi_ss_i  (spi_ss_o)
  );

  always #5 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Four flash bytes from addr on, first byte on top
  function automatic logic [31:0] expected_flash_word(input logic [23:0] addr);
    logic [31:0] word;
    logic [7:0]  low;
    word = '0;
    for (int i = 0; i < 4; i++) begin
      low = addr[7:0] + 8'(i);
      word = {word[23:0], low ^ 8'hA5};
    end
    return word;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_ss(input string name, input logic [SS_NUM-1:0] got,
                          input logic [SS_NUM-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One APB transfer, response sampled on the falling edge
  task automatic apb_access(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clock);
    paddr <= addr;
    pwrite <= write;
    pwdata <= wdata;
    pstrb <= 4'hF;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    do begin
      @(negedge clock);
    end while (!pready);
    rdata = prdata;
    err = pslverr;
    @(posedge clock);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(addr, 1'b0, '0, data, err);
  endtask

  // Register window address of an offset
  function automatic logic [31:0] reg_addr(input logic [spi_pkg::REG_ADDR_W-1:0] ofs);
    return REGS_BASE + 32'(ofs);
  endfunction

  task automatic test_reset_state();
    @(negedge clock);
    check_ss("spi_ss_o", spi_ss, '1);
    check_flag("spi_sck_o", spi_sck, 1'b0);
    check_flag("spi_irq_o", spi_irq, 1'b0);
    check_flag("pready_o", pready, 1'b0);
    check_flag("pslverr_o", pslverr, 1'b0);
  endtask

  task automatic test_register_access();
    logic [31:0] data;
    logic        err;
    apb_write(reg_addr(spi_pkg::DIVIDER_OFS), 32'h0000_00A7, err);
    check_flag("pslverr_o", err, 1'b0);
    apb_write(reg_addr(spi_pkg::RX0_TX0_OFS), 32'hC0FF_EE11, err);
    check_flag("pslverr_o", err, 1'b0);
    apb_write(reg_addr(spi_pkg::RX1_TX1_OFS), 32'h5A5A_1234, err);
    check_flag("pslverr_o", err, 1'b0);
    apb_read(reg_addr(spi_pkg::DIVIDER_OFS), data, err);
    check_word("divider", data, 32'h0000_00A7);
    // Data offsets read RX, still clear with no transfer yet
    apb_read(reg_addr(spi_pkg::RX0_TX0_OFS), data, err);
    check_word("rx0", data, 32'h0);
    apb_read(reg_addr(spi_pkg::RX1_TX1_OFS), data, err);
    check_word("rx1", data, 32'h0);
    apb_write(reg_addr(spi_pkg::SS_OFS), 32'h05, err);
    @(negedge clock);
    check_ss("spi_ss_o", spi_ss, 8'hFA);
    apb_read(reg_addr(spi_pkg::SS_OFS), data, err);
    check_word("ss", data, 32'h05);
  endtask

  task automatic test_manual_transfer();
    logic [31:0]        rnd;
    logic [23:0]        addr;
    logic [31:0]        data;
    logic               err;
    spi_pkg::spi_ctrl_u ctrl;
    rnd = next_random();
    addr = rnd[23:0];
    apb_write(reg_addr(spi_pkg::SS_OFS), 32'h01, err);
    apb_write(reg_addr(spi_pkg::RX1_TX1_OFS), {spi_pkg::XIP_READ_CMD, addr}, err);
    apb_write(reg_addr(spi_pkg::DIVIDER_OFS), 32'(MANUAL_DIV), err);
    // Full 64 bits with interrupt
    ctrl.raw = '0;
    ctrl.f.char_len = '0;
    ctrl.f.ie = 1'b1;
    ctrl.f.go_bsy = 1'b1;
    apb_write(reg_addr(spi_pkg::CTRL_OFS), ctrl.raw, err);
    check_flag("pslverr_o", err, 1'b0);
    do begin
      apb_read(reg_addr(spi_pkg::CTRL_OFS), data, err);
      ctrl.raw = data;
    end while (ctrl.f.go_bsy);
    apb_read(reg_addr(spi_pkg::RX0_TX0_OFS), data, err);
    check_word("rx0", data, expected_flash_word(addr));
    @(negedge clock);
    check_flag("spi_irq_o", spi_irq, 1'b1);
    apb_write(reg_addr(spi_pkg::CTRL_OFS), 32'h0, err);
    @(negedge clock);
    check_flag("spi_irq_o", spi_irq, 1'b0);
    check_word("flash command", flash_cmd, {spi_pkg::XIP_READ_CMD, addr});
    apb_write(reg_addr(spi_pkg::SS_OFS), 32'h0, err);
    @(negedge clock);
    check_ss("spi_ss_o", spi_ss, '1);
  endtask

  task automatic test_xip_reads();
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    logic        err;
    for (int n = 0; n < XIP_READS; n++) begin
      rnd = next_random();
      addr = FLASH_BASE | {4'h0, rnd[27:0]};
      apb_read(addr, data, err);
      check_flag("pslverr_o", err, 1'b0);
      check_word("prdata_o", data, expected_flash_word(addr[23:0]));
      check_word("flash command", flash_cmd, {spi_pkg::XIP_READ_CMD, addr[23:0]});
      @(negedge clock);
      check_ss("spi_ss_o", spi_ss, '1);
    end
  endtask

  task automatic test_error_responses();
    logic [31:0] data;
    logic        err;
    // Outside both windows
    apb_read(32'h2000_0000, data, err);
    check_flag("pslverr_o", err, 1'b1);
    // Flash is read only
    apb_write(FLASH_BASE + 32'h100, 32'hDEAD_BEEF, err);
    check_flag("pslverr_o", err, 1'b1);
    // Hole in the register map
    apb_read(REGS_BASE + 32'h0C, data, err);
    check_flag("pslverr_o", err, 1'b1);
  endtask

  initial begin
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    pstrb = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    test_reset_state();
    test_register_access();
    test_manual_transfer();
    test_xip_reads();
    test_error_responses();
    repeat (2) @(posedge clock);
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, dut.u_assert.fail_count);
    if (error_count == 0 && dut.u_assert.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
logic/spi_pkg.sv
logic/spi_reg_if.sv
logic/spi_shift_if.sv
logic/apb_xip_front.sv
logic/spi_master_regs.sv
logic/spi_shifter.sv
logic/spi_apb_bridge.sv
verif/spi_flash_model.sv
verif/spi_apb_assertions.sv
verif/tb_spi_apb_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_spi_apb_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
